// ==== src/fp_pkg.sv ====
package fp_pkg;

    // ieee single precision fields
    typedef logic [31:0] word_t;           // packed float word
    typedef logic [7:0]  exp_t;            // biased exponent
    typedef logic [22:0] frac_t;           // stored fraction
    typedef logic [23:0] mant_t;           // fraction with hidden bit

    // five bit alu op codes, 3 and anything above 7 is unsupported
    typedef enum logic [4:0] {
        OP_ADD      = 5'd0,
        OP_SUB      = 5'd1,
        OP_MUL      = 5'd2,
        OP_MIN      = 5'd4,
        OP_MAX      = 5'd5,
        OP_PASS     = 5'd6,
        OP_PASS_ALT = 5'd7
    } op_t;

    localparam exp_t EXP_BIAS = 8'd127;    // single precision bias
    localparam exp_t EXP_MAX  = 8'd255;    // saturated exponent

endpackage

// ==== src/fp_lzc.sv ====
`timescale 1ns/10ps

module fp_lzc #(
    parameter int WIDTH = 25
) (
    input  logic [WIDTH-1:0]              value,
    output logic [$clog2(WIDTH+1)-1:0]    count
);

    localparam int CW = $clog2(WIDTH + 1);

    // priority encode the first set bit from the top
    always_comb begin
        count = CW'(WIDTH);                  // all zeros
        for (int i = 0; i < WIDTH; i++) begin
            if (value[i]) begin
                count = CW'(WIDTH - 1 - i);  // higher bits overwrite lower ones
            end
        end
    end

endmodule

// ==== src/fp_operand_stage.sv ====
`timescale 1ns/10ps

module fp_operand_stage (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          in_valid,
    input  fp_pkg::op_t   op,
    input  fp_pkg::word_t a,
    input  fp_pkg::word_t b,
    output logic          stage_valid,
    output fp_pkg::op_t   stage_op,
    output logic          sign_a,
    output logic          sign_b,
    output fp_pkg::exp_t  exp_a,
    output fp_pkg::exp_t  exp_b,
    output fp_pkg::mant_t mant_a,
    output fp_pkg::mant_t mant_b,
    output logic          a_is_larger,
    output fp_pkg::word_t min_max_word
);

    import fp_pkg::*;

    word_t a_q;
    word_t b_q;
    frac_t frac_a;
    frac_t frac_b;
    logic  a_mag_gt;
    logic  b_mag_gt;
    logic  a_lt_b;
    logic  b_lt_a;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            stage_op <= op;
            a_q      <= a;
            b_q      <= b;
        end
    end

    // unpack, inputs are always normal so the hidden bit is set
    assign sign_a = a_q[31];
    assign sign_b = b_q[31];
    assign exp_a  = a_q[30:23];
    assign exp_b  = b_q[30:23];
    assign frac_a = a_q[22:0];
    assign frac_b = b_q[22:0];
    assign mant_a = {1'b1, frac_a};
    assign mant_b = {1'b1, frac_b};

    // magnitude compare, exponent first
    assign a_mag_gt = (exp_a > exp_b) || ((exp_a == exp_b) && (frac_a > frac_b));
    assign b_mag_gt = (exp_b > exp_a) || ((exp_a == exp_b) && (frac_b > frac_a));
    assign a_is_larger = a_mag_gt;           // a tie counts as b larger

    // signed magnitude order, a negative value with bigger magnitude is smaller
    assign a_lt_b = (sign_a != sign_b) ? sign_a : (sign_a ? a_mag_gt : b_mag_gt);
    assign b_lt_a = (sign_a != sign_b) ? sign_b : (sign_a ? b_mag_gt : a_mag_gt);

    always_comb begin
        case (stage_op)
            OP_MIN:  min_max_word = b_lt_a ? b_q : a_q;
            OP_MAX:  min_max_word = a_lt_b ? b_q : a_q;
            default: min_max_word = a_q;     // pass and ties keep a
        endcase
    end

    // only normal operands are handled by the datapath
    a_normal_operands: assert property (
        @(posedge clk) disable iff (!arst_n)
        in_valid |-> (a[30:23] != '0) && (a[30:23] != EXP_MAX) &&
                     (b[30:23] != '0) && (b[30:23] != EXP_MAX)
    ) else $error("an operand that is not a normal number was accepted");

endmodule

// ==== src/fp_addsub.sv ====
`timescale 1ns/10ps

module fp_addsub (
    input  fp_pkg::op_t   op,
    input  logic          sign_a,
    input  logic          sign_b,
    input  fp_pkg::exp_t  exp_a,
    input  fp_pkg::exp_t  exp_b,
    input  fp_pkg::mant_t mant_a,
    input  fp_pkg::mant_t mant_b,
    input  logic          a_is_larger,
    output fp_pkg::word_t sum_word,
    output logic          sum_error
);

    import fp_pkg::*;

    logic        sign_b_eff;
    logic        sign_big;
    exp_t        exp_big;
    exp_t        exp_small;
    exp_t        exp_diff;
    mant_t       mant_big;
    mant_t       mant_small;
    mant_t       mant_align;
    logic [24:0] mant_sum;                   // one extra bit for the carry
    logic [24:0] mant_norm;
    logic [4:0]  lead_zeros;
    logic [9:0]  exp_up;
    logic [9:0]  exp_wide;
    frac_t       frac;

    assign sign_b_eff = sign_b ^ (op == OP_SUB);    // subtract is add of -b

    // larger operand sets sign and exponent
    assign sign_big   = a_is_larger ? sign_a : sign_b_eff;
    assign exp_big    = a_is_larger ? exp_a  : exp_b;
    assign exp_small  = a_is_larger ? exp_b  : exp_a;
    assign mant_big   = a_is_larger ? mant_a : mant_b;
    assign mant_small = a_is_larger ? mant_b : mant_a;

    assign exp_diff   = exp_big - exp_small;
    assign mant_align = mant_small >> exp_diff;     // shifted out bits are lost

    assign mant_sum = (sign_a == sign_b_eff) ? {1'b0, mant_big} + {1'b0, mant_align}
                                             : {1'b0, mant_big} - {1'b0, mant_align};

    fp_lzc #(
        .WIDTH (25)
    ) u_lzc (
        .value (mant_sum),
        .count (lead_zeros)
    );

    // a carry leaves lead_zeros at 0, so the leading one sits at bit 24 after
    // the shift in both cases and the exponent is exp_big + 1 - lead_zeros
    always_comb begin
        mant_norm = mant_sum << lead_zeros;
        frac      = mant_norm[23:1];
        exp_up    = {2'b00, exp_big} + 10'd1;
        exp_wide  = exp_up - {5'd0, lead_zeros};
    end

    always_comb begin
        if (mant_sum == '0) begin
            sum_word  = '0;                  // exact cancellation
            sum_error = 1'b0;
        end else if (exp_up <= {5'd0, lead_zeros}) begin
            sum_word  = '0;                  // underflow
            sum_error = 1'b1;
        end else if (exp_wide >= 10'(EXP_MAX)) begin
            sum_word  = {sign_big, EXP_MAX, 23'd0};
            sum_error = 1'b1;
        end else begin
            sum_word  = {sign_big, exp_wide[7:0], frac};
            sum_error = 1'b0;
        end
    end

endmodule

// ==== src/fp_mult.sv ====
`timescale 1ns/10ps

module fp_mult (
    input  logic          sign_a,
    input  logic          sign_b,
    input  fp_pkg::exp_t  exp_a,
    input  fp_pkg::exp_t  exp_b,
    input  fp_pkg::mant_t mant_a,
    input  fp_pkg::mant_t mant_b,
    output fp_pkg::word_t prod_word,
    output logic          prod_error
);

    import fp_pkg::*;

    logic [47:0] product;
    logic        norm;
    logic        sign_p;
    logic [9:0]  exp_raw;
    logic [9:0]  exp_wide;
    frac_t       frac;

    assign product = mant_a * mant_b;        // 1.x * 1.x lies in [1, 4)
    assign norm    = product[47];
    assign sign_p  = sign_a ^ sign_b;

    // truncate below the 23 kept fraction bits
    assign frac = norm ? product[46:24] : product[45:23];

    // bias is subtracted after the compare so the sum never wraps
    assign exp_raw  = {2'b00, exp_a} + {2'b00, exp_b} + {9'd0, norm};
    assign exp_wide = exp_raw - 10'(EXP_BIAS);

    always_comb begin
        if (exp_raw <= 10'(EXP_BIAS)) begin
            prod_word  = {sign_p, 31'd0};    // signed zero
            prod_error = 1'b1;
        end else if (exp_wide >= 10'(EXP_MAX)) begin
            prod_word  = {sign_p, EXP_MAX, 23'd0};
            prod_error = 1'b1;
        end else begin
            prod_word  = {sign_p, exp_wide[7:0], frac};
            prod_error = 1'b0;
        end
    end

endmodule

// ==== src/fp_result_queue.sv ====
`timescale 1ns/10ps

module fp_result_queue #(
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          wr_valid,
    input  fp_pkg::word_t wr_word,
    input  logic          wr_error,
    input  logic          out_credit,
    output logic          in_credit,
    output logic          out_valid,
    output fp_pkg::word_t result,
    output logic          error
);

    import fp_pkg::*;

    localparam int AW   = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNTW = $clog2(QUEUE_DEPTH + 1);
    localparam int CRW  = $clog2(OUT_CREDITS + 1);

    word_t           mem_word [QUEUE_DEPTH];
    logic            mem_err  [QUEUE_DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CNTW-1:0] fill;
    logic [CRW-1:0]  credits;
    logic            pop;

    // send only when something is queued and downstream has room
    assign pop = (fill != '0) && (credits != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fill      <= '0;
            credits   <= CRW'(OUT_CREDITS);
            out_valid <= 1'b0;
            in_credit <= 1'b0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= (wr_ptr == AW'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            fill      <= fill + CNTW'(wr_valid) - CNTW'(pop);
            credits   <= credits + CRW'(out_credit) - CRW'(pop);
            out_valid <= pop;
            in_credit <= pop;                // freed entry goes back upstream
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem_word[wr_ptr] <= wr_word;
            mem_err[wr_ptr]  <= wr_error;
        end
        if (pop) begin
            result <= mem_word[rd_ptr];
            error  <= mem_err[rd_ptr];
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (!arst_n) wr_valid |-> (fill < CNTW'(QUEUE_DEPTH))
    ) else $error("result written into a full queue, upstream sent without a credit");

    a_credit_bound: assert property (
        @(posedge clk) disable iff (!arst_n) credits <= CRW'(OUT_CREDITS)
    ) else $error("downstream returned more credits than it was given");

endmodule

// ==== src/fp_alu.sv ====
`timescale 1ns/10ps

module fp_alu #(
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          in_valid,
    input  fp_pkg::op_t   op,
    input  fp_pkg::word_t a,
    input  fp_pkg::word_t b,
    input  logic          out_credit,
    output logic          in_credit,
    output logic          out_valid,
    output fp_pkg::word_t result,
    output logic          error
);

    import fp_pkg::*;

    logic  stage_valid;
    op_t   stage_op;
    logic  sign_a;
    logic  sign_b;
    exp_t  exp_a;
    exp_t  exp_b;
    mant_t mant_a;
    mant_t mant_b;
    logic  a_is_larger;
    word_t min_max_word;
    word_t sum_word;
    logic  sum_error;
    word_t prod_word;
    logic  prod_error;
    word_t sel_word;
    logic  sel_error;

    fp_operand_stage u_operand_stage (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .op           (op),
        .a            (a),
        .b            (b),
        .stage_valid  (stage_valid),
        .stage_op     (stage_op),
        .sign_a       (sign_a),
        .sign_b       (sign_b),
        .exp_a        (exp_a),
        .exp_b        (exp_b),
        .mant_a       (mant_a),
        .mant_b       (mant_b),
        .a_is_larger  (a_is_larger),
        .min_max_word (min_max_word)
    );

    fp_addsub u_addsub (
        .op          (stage_op),
        .sign_a      (sign_a),
        .sign_b      (sign_b),
        .exp_a       (exp_a),
        .exp_b       (exp_b),
        .mant_a      (mant_a),
        .mant_b      (mant_b),
        .a_is_larger (a_is_larger),
        .sum_word    (sum_word),
        .sum_error   (sum_error)
    );

    fp_mult u_mult (
        .sign_a     (sign_a),
        .sign_b     (sign_b),
        .exp_a      (exp_a),
        .exp_b      (exp_b),
        .mant_a     (mant_a),
        .mant_b     (mant_b),
        .prod_word  (prod_word),
        .prod_error (prod_error)
    );

    // pick the datapath result for the staged op
    always_comb begin
        case (stage_op)
            OP_ADD, OP_SUB: begin
                sel_word  = sum_word;
                sel_error = sum_error;
            end
            OP_MUL: begin
                sel_word  = prod_word;
                sel_error = prod_error;
            end
            OP_MIN, OP_MAX, OP_PASS, OP_PASS_ALT: begin
                sel_word  = min_max_word;
                sel_error = 1'b0;
            end
            default: begin
                sel_word  = '0;              // unsupported code
                sel_error = 1'b1;
            end
        endcase
    end

    // the queue registers the result one edge after operand capture
    fp_result_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_result_queue (
        .clk        (clk),
        .arst_n     (arst_n),
        .wr_valid   (stage_valid),
        .wr_word    (sel_word),
        .wr_error   (sel_error),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .result     (result),
        .error      (error)
    );

endmodule

// ==== testbench/tb_fp_alu.sv ====
`timescale 1ns/10ps

module tb_fp_alu;

    import fp_pkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int OUT_CREDITS = 2;
    localparam int CLK_PERIOD  = 40;
    localparam int MAX_LINES   = 64;
    localparam int FIELDS      = 5;          // op, a, b, result, error

    logic  clk;
    logic  arst_n;
    logic  in_valid;
    op_t   op;
    word_t a;
    word_t b;
    logic  out_credit;
    logic  in_credit;
    logic  out_valid;
    word_t result;
    logic  error;

    logic [31:0] trace_mem [MAX_LINES*FIELDS];
    int          n_lines;
    bit          trace_ready;
    word_t       exp_word_q [$];             // expected values in trace order
    logic        exp_err_q [$];
    int          sent;
    int          received;
    int          in_returned;                // in_credit pulses seen
    int          out_returned;               // output credits handed back
    int          pass_count;
    int          fail_count;
    logic [31:0] lcg_state;

    fp_alu #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_fp_alu (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .op         (op),
        .a          (a),
        .b          (b),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .result     (result),
        .error      (error)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic compare_word(input string name, input word_t got, input word_t expected,
                                inout bit ok);
        if (got !== expected) begin
            $display("FAILED at %t: %s got %h expected %h", $time, name, got, expected);
            ok = 1'b0;
        end
    endtask

    task automatic compare_error(input string name, input logic got, input logic expected,
                                 inout bit ok);
        if (got !== expected) begin
            $display("FAILED at %t: %s got %b expected %b", $time, name, got, expected);
            ok = 1'b0;
        end
    endtask

    // stimulus follows the upstream credit count
    initial begin : stimulus
        int i;
        int base;
        bit end_ok;
        $timeformat(-9, 1, " ns", 10);
        arst_n   = 1'b0;
        in_valid = 1'b0;
        op       = OP_ADD;
        a        = '0;
        b        = '0;
        for (i = 0; i < MAX_LINES * FIELDS; i++) begin
            trace_mem[i] = '1;               // end marker in the op column
        end
        $readmemh("testbench/fp_alu_trace.txt", trace_mem);
        n_lines = 0;
        while (n_lines < MAX_LINES && trace_mem[n_lines*FIELDS] != '1) begin
            n_lines++;
        end
        trace_ready = 1'b1;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        i = 0;
        while (i < n_lines) begin
            @(posedge clk);
            if (QUEUE_DEPTH + in_returned > sent) begin
                base = i * FIELDS;
                in_valid <= 1'b1;
                op       <= op_t'(trace_mem[base][4:0]);
                a        <= trace_mem[base+1];
                b        <= trace_mem[base+2];
                exp_word_q.push_back(trace_mem[base+3]);
                exp_err_q.push_back(trace_mem[base+4][0]);
                sent++;
                i++;
            end else begin
                in_valid <= 1'b0;            // out of credits
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        wait (received == n_lines);
        repeat (4) @(posedge clk);           // catch any stray result
        end_ok = (fail_count == 0) && (n_lines > 0);
        if (n_lines == 0) begin
            $display("the trace file held no operations");
        end
        if (in_returned != received) begin
            $display("input credits returned %0d but results delivered %0d",
                     in_returned, received);
            end_ok = 1'b0;
        end
        $display("tests %0d, passed %0d, failed %0d", n_lines, pass_count, fail_count);
        if (end_ok) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // downstream returns a credit at random for each result it took
    initial begin : credit_return
        out_credit = 1'b0;
        lcg_state  = 32'd72;
        forever begin
            @(posedge clk);
            lcg_state = lcg_step(lcg_state);
            if (arst_n && (received > out_returned) && lcg_state[16]) begin
                out_credit <= 1'b1;
                out_returned++;
            end else begin
                out_credit <= 1'b0;
            end
        end
    end

    // outputs are sampled on the falling edge
    initial begin : monitor
        bit    ok;
        int    idx;
        int    credit_seen;                  // out_credit pulses seen so far
        int    credit_used;                  // those the DUT could spend on this pop
        word_t exp_word;
        logic  exp_err;
        forever begin
            @(negedge clk);
            if (in_credit) begin
                in_returned++;
            end
            if (out_valid) begin
                idx = received;
                received++;
                if (received > OUT_CREDITS + credit_used) begin
                    $display("result %0d came out while no output credit was left", idx);
                    fail_count++;
                end
                if (exp_word_q.size() == 0) begin
                    $display("a result arrived with no operation waiting for it");
                    fail_count++;
                end else begin
                    ok       = 1'b1;
                    exp_word = exp_word_q.pop_front();
                    exp_err  = exp_err_q.pop_front();
                    compare_word("result", result, exp_word, ok);
                    compare_error("error", error, exp_err, ok);
                    if (ok) begin
                        pass_count++;
                        $display("test %0d op %0d: result %h error %b ok",
                                 idx, trace_mem[idx*FIELDS][4:0], result, error);
                    end else begin
                        fail_count++;
                        $display("test %0d op %0d: mismatch", idx, trace_mem[idx*FIELDS][4:0]);
                    end
                end
            end
            // a credit seen now is sampled at the next edge and counts one edge later
            credit_used = credit_seen;
            if (out_credit) begin
                credit_seen++;
            end
        end
    end

    initial begin : watchdog
        wait (trace_ready);
        repeat ((n_lines + 1) * 20) @(posedge clk);
        $display("timeout: results stopped arriving, %0d of %0d delivered", received, n_lines);
        $display("tests %0d, passed %0d, failed %0d", n_lines, pass_count, fail_count);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== list.f ====
src/fp_pkg.sv
src/fp_lzc.sv
src/fp_operand_stage.sv
src/fp_addsub.sv
src/fp_mult.sv
src/fp_result_queue.sv
src/fp_alu.sv
testbench/tb_fp_alu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the fp_alu testbench with Verilator, from the project root.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fp_alu -f list.f -o tb_fp_alu_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_fp_alu_sim 2>&1 | tee "$SIM_LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$SIM_LOG"; then
    exit 1
fi
exit 0

// ==== testbench/fp_alu_trace.txt ====
// columns: op a b expected_result expected_error, all in hex
// op codes: 0 add, 1 sub, 2 mul, 4 min, 5 max, 6 pass, 7 pass_alt
00 3f800000 40000000 40400000 0
00 3fe00000 3fc00000 40500000 0
00 3f800000 3f000001 3fc00000 0
00 40400000 bf800000 40000000 0
01 3f800000 3f400000 3e800000 0
01 3f800000 40400000 c0000000 0
00 bfc00000 c0200000 c0800000 0
01 3fc00000 3fc00000 00000000 0
00 7f7fffff 7f7fffff 7f800000 1
01 00800001 00800000 00000000 1
02 3fc00000 40000000 40400000 0
02 3fc00000 3fc00000 40100000 0
02 c0400000 3f800001 c0400001 0
02 7e800000 40000000 7f000000 0
02 7f000000 40000000 7f800000 1
02 80800000 00800000 80000000 1
04 3f800000 40000000 3f800000 0
05 3f800000 40000000 40000000 0
04 bf800000 40000000 bf800000 0
05 bf800000 40000000 40000000 0
04 3f800000 c0000000 c0000000 0
05 3f800000 c0000000 3f800000 0
04 bf800000 c0000000 c0000000 0
05 bf800000 c0000000 bf800000 0
04 c0490fdb c0490fdb c0490fdb 0
05 c0490fdb c0490fdb c0490fdb 0
06 c0490fdb 3f800000 c0490fdb 0
07 12345678 40000000 12345678 0
03 3f800000 40000000 00000000 1
09 3f800000 40000000 00000000 1
